// File: files.f
source/rv_isa_pkg.sv
source/mem_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/data_mem.sv
source/load_result.sv
source/lsu_top.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module lsu_tb -f files.f -o lsu_sim
	obj_dir/lsu_sim | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/lsu_tb.sv
`default_nettype none

module lsu_tb
  import rv_isa_pkg::*;
  import mem_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int NUM_RANDOM   = 400;
  localparam int MARGIN       = 50;

  logic     clk;
  logic     reset;
  logic     valid;
  instr_t   instr;
  xlen_t    rs1_val;
  xlen_t    rs2_val;
  logic     done;
  logic     rd_we;
  reg_idx_t rd;
  xlen_t    rd_data;
  logic     fault;

  // stimulus table, one entry per operation
  string  t_name[$];
  instr_t t_instr[$];
  xlen_t  t_rs1[$];
  xlen_t  t_rs2[$];
  logic   t_we[$];
  xlen_t  t_data[$];
  logic   t_fault[$];

  xlen_t       ref_mem [MEM_WORDS];
  logic [31:0] lcg_state;
  int          cycles;
  int          cycle_limit;
  int          pass_count;
  int          fail_count;

  lsu_top DUT (
    .clk     (clk),
    .reset   (reset),
    .valid   (valid),
    .instr   (instr),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .done    (done),
    .rd_we   (rd_we),
    .rd      (rd),
    .rd_data (rd_data),
    .fault   (fault)
  );

  always #5 clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic instr_t load_instr(funct3_t f3, reg_idx_t dst, logic [11:0] imm);
    return {imm, 5'd1, f3, dst, OPC_LOAD};
  endfunction

  function automatic instr_t store_instr(funct3_t f3, logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  // expected load value, gathered byte by byte then extended
  function automatic xlen_t load_value(xlen_t word, byte_off_t off, funct3_t f3);
    int    nbytes;
    xlen_t val;
    nbytes = 1 << f3[1:0];
    val    = '0;
    for (int b = 0; b < nbytes; b++) begin
      val[b*8 +: 8] = word[(int'(off) + b)*8 +: 8];
    end
    // bit 2 of funct3 selects the unsigned forms
    if (!f3[2] && nbytes < 8 && val[nbytes*8-1]) begin
      for (int b = nbytes; b < 8; b++) begin
        val[b*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  // reference model for legal loads and stores
  task automatic predict(input instr_t ins, input xlen_t rs1, input xlen_t rs2,
                         output logic we, output xlen_t data, output logic flt);
    xlen_t     imm;
    xlen_t     addr;
    funct3_t   f3;
    word_idx_t idx;
    logic      is_ld;
    int        nbytes;
    int        off_i;
    is_ld  = (ins[6:0] == OPC_LOAD);
    f3     = ins[14:12];
    imm    = is_ld ? {{52{ins[31]}}, ins[31:20]} : {{52{ins[31]}}, ins[31:25], ins[11:7]};
    addr   = rs1 + imm;
    idx    = addr[10:3];
    off_i  = int'(addr[2:0]);
    nbytes = 1 << f3[1:0];
    flt    = (off_i % nbytes) != 0;
    we     = 1'b0;
    data   = '0;
    if (!flt && !is_ld) begin
      for (int b = 0; b < nbytes; b++) begin
        ref_mem[idx][(off_i + b)*8 +: 8] = rs2[b*8 +: 8];
      end
    end
    if (!flt && is_ld && ins[11:7] != 5'd0) begin
      we   = 1'b1;
      data = load_value(ref_mem[idx], addr[2:0], f3);
    end
  endtask

  task automatic add_entry(input string name, input instr_t ins, input xlen_t rs1,
                           input xlen_t rs2, input logic we, input xlen_t data,
                           input logic flt);
    t_name.push_back(name);
    t_instr.push_back(ins);
    t_rs1.push_back(rs1);
    t_rs2.push_back(rs2);
    t_we.push_back(we);
    t_data.push_back(data);
    t_fault.push_back(flt);
  endtask

  task automatic build_table();
    xlen_t   d;
    funct3_t f3;
    int      nbytes;
    string   mn [7];
    mn = '{"lb", "lh", "lw", "ld", "lbu", "lhu", "lwu"};
    d  = 64'h80ff_7f01_c3a5_5a3c;
    add_entry("sd_base", store_instr(F3_D, 12'h000), 64'h100, d, 1'b0, '0, 1'b0);
    // every load form at every aligned offset
    for (int f = 0; f < 7; f++) begin
      f3     = funct3_t'(f);
      nbytes = 1 << f3[1:0];
      for (int off = 0; off < 8; off += nbytes) begin
        add_entry($sformatf("%s_off%0d", mn[f], off), load_instr(f3, 5'd5, 12'(off)),
                  64'h100, '0, 1'b1, load_value(d, byte_off_t'(off), f3), 1'b0);
      end
    end
    // single lanes, upper bytes of rs2 must be dropped
    add_entry("sb_lane2", store_instr(F3_B, 12'h002), 64'h100, 64'hdead_beef_cafe_0011,
              1'b0, '0, 1'b0);
    add_entry("sb_lane5", store_instr(F3_B, 12'h005), 64'h100, 64'h1234_5678_9abc_de22,
              1'b0, '0, 1'b0);
    add_entry("ld_lanes", load_instr(F3_D, 5'd5, 12'h000), 64'h100, '0,
              1'b1, 64'h80ff_2201_c311_5a3c, 1'b0);
    add_entry("lh_misal", load_instr(F3_H, 5'd5, 12'h003), 64'h100, '0, 1'b0, '0, 1'b1);
    add_entry("lw_misal", load_instr(F3_W, 5'd5, 12'h006), 64'h100, '0, 1'b0, '0, 1'b1);
    add_entry("sd_misal", store_instr(F3_D, 12'h004), 64'h100, '1, 1'b0, '0, 1'b1);
    add_entry("sh_misal", store_instr(F3_H, 12'h001), 64'h100, '1, 1'b0, '0, 1'b1);
    add_entry("ld_after_misal", load_instr(F3_D, 5'd5, 12'h000), 64'h100, '0,
              1'b1, 64'h80ff_2201_c311_5a3c, 1'b0);
    // add x5, x1, x1
    add_entry("bad_opcode", 32'h0010_82b3, 64'h100, '1, 1'b0, '0, 1'b1);
    add_entry("load_f3_7", load_instr(3'd7, 5'd5, 12'h000), 64'h100, '0, 1'b0, '0, 1'b1);
    add_entry("store_f3_5", store_instr(3'd5, 12'h000), 64'h100, '1, 1'b0, '0, 1'b1);
    add_entry("ld_after_illegal", load_instr(F3_D, 5'd5, 12'h000), 64'h100, '0,
              1'b1, 64'h80ff_2201_c311_5a3c, 1'b0);
    add_entry("ld_rd0", load_instr(F3_D, 5'd0, 12'h000), 64'h100, '0, 1'b0, '0, 1'b0);
    // bits above 2 KiB are ignored
    add_entry("ld_wrap", load_instr(F3_D, 5'd7, 12'h000), 64'h4000_0000_0000_0900, '0,
              1'b1, 64'h80ff_2201_c311_5a3c, 1'b0);
  endtask

  // drives one operation and checks its result in the following cycle
  task automatic run_op(input string name, input instr_t ins, input xlen_t rs1,
                        input xlen_t rs2, input logic exp_we, input xlen_t exp_data,
                        input logic exp_fault, input logic show);
    int errs;
    valid   = 1'b1;
    instr   = ins;
    rs1_val = rs1;
    rs2_val = rs2;
    @(posedge clk);
    #1;
    errs = 0;
    assert (done === 1'b1) else begin
      $display("%s: done did not pulse in the cycle after the operation", name);
      errs++;
    end
    assert (rd_we === exp_we) else begin
      $display("FAILED %s rd_we expected %0b actual %0b", name, exp_we, rd_we);
      errs++;
    end
    assert (rd_data === exp_data) else begin
      $display("FAILED %s rd_data expected %h actual %h", name, exp_data, rd_data);
      errs++;
    end
    assert (fault === exp_fault) else begin
      $display("FAILED %s fault expected %0b actual %0b", name, exp_fault, fault);
      errs++;
    end
    // a write-back names the destination field of the load
    if (exp_we) begin
      assert (rd === ins[11:7]) else begin
        $display("FAILED %s rd expected %0d actual %0d", name, ins[11:7], rd);
        errs++;
      end
    end
    if (errs == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    if (show) begin
      $display("%s: %s", name, (errs == 0) ? "pass" : "fail");
    end
  endtask

  initial begin
    instr_t      ins;
    xlen_t       rs1;
    xlen_t       rs2;
    xlen_t       target;
    xlen_t       data;
    logic        we;
    logic        flt;
    logic        is_st;
    funct3_t     f3;
    byte_off_t   off;
    word_idx_t   idx;
    word_idx_t   last_idx;
    logic [11:0] imm;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    int          phase_fail;
    clk        = 1'b0;
    reset      = 1'b1;
    valid      = 1'b0;
    instr      = '0;
    rs1_val    = '0;
    rs2_val    = '0;
    cycles     = 0;
    pass_count = 0;
    fail_count = 0;
    lcg_state  = 32'd52;
    last_idx   = '0;
    build_table();
    cycle_limit = RESET_CYCLES + t_name.size() + MEM_WORDS + NUM_RANDOM + MARGIN;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (t_name[i]) begin
      run_op(t_name[i], t_instr[i], t_rs1[i], t_rs2[i], t_we[i], t_data[i], t_fault[i], 1'b1);
    end
    // known contents everywhere before random loads
    phase_fail = fail_count;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ins = store_instr(F3_D, 12'h000);
      rs1 = {53'd0, i[7:0], 3'b000};
      rs2 = {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
      predict(ins, rs1, rs2, we, data, flt);
      run_op($sformatf("fill%0d", i), ins, rs1, rs2, we, data, flt, 1'b0);
    end
    $display("fill: %0d stores, %0d failed", MEM_WORDS, fail_count - phase_fail);
    phase_fail = fail_count;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r1    = next_random();
      r2    = next_random();
      r3    = next_random();
      r4    = next_random();
      is_st = r1[31];
      f3    = is_st ? {1'b0, r1[29:28]} : r1[30:28];
      if (!is_st && f3 == 3'd7) begin
        f3 = F3_D;
      end
      // often hit the word of the previous operation
      idx = (r1[27:26] == 2'd0) ? last_idx : r1[25:18];
      off = r1[17:15];
      if (r1[14:12] != 3'd0) begin
        off = off & ~3'((1 << f3[1:0]) - 1);
      end
      imm    = r2[11:0];
      target = {r3, r2[31:11], idx, off};
      rs1    = target - {{52{imm[11]}}, imm};
      rs2    = {r4, r3};
      ins    = is_st ? store_instr(f3, imm) : load_instr(f3, r1[11:7], imm);
      predict(ins, rs1, rs2, we, data, flt);
      run_op($sformatf("rand%0d", n), ins, rs1, rs2, we, data, flt, 1'b0);
      last_idx = idx;
    end
    $display("random: %0d operations, %0d failed", NUM_RANDOM, fail_count - phase_fail);
    valid = 1'b0;
    @(posedge clk);
    #1;
    $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/lsu_chk.sv
`default_nettype none

module lsu_chk
  import rv_isa_pkg::*;
(
  input wire logic  clk,
  input wire logic  reset,
  input wire logic  valid,
  input wire logic  done,
  input wire logic  rd_we,
  input wire logic  fault,
  input wire xlen_t rd_data
);

  // fixed one-cycle latency, every strobe accepted
  done_latency: assert property (@(posedge clk) disable iff (reset) done == $past(valid))
    else $error("done does not follow valid by one cycle");

  we_has_done: assert property (@(posedge clk) disable iff (reset) rd_we |-> done)
    else $error("rd_we high without done");

  // refused accesses never write back
  we_fault_excl: assert property (@(posedge clk) disable iff (reset) !(rd_we && fault))
    else $error("rd_we and fault high together");

  quiet_data: assert property (@(posedge clk) disable iff (reset) !rd_we |-> rd_data == '0)
    else $error("rd_data nonzero while rd_we is low");

endmodule

bind lsu_top lsu_chk u_chk (
  .clk     (clk),
  .reset   (reset),
  .valid   (valid),
  .done    (done),
  .rd_we   (rd_we),
  .fault   (fault),
  .rd_data (rd_data)
);

`default_nettype wire

// File: source/lsu_top.sv
`default_nettype none

module lsu_top
  import rv_isa_pkg::*;
  import mem_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   valid,
  input  wire instr_t instr,
  input  wire xlen_t  rs1_val,
  input  wire xlen_t  rs2_val,
  output logic        done,
  output logic        rd_we,
  output reg_idx_t    rd,
  output xlen_t       rd_data,
  output logic        fault
);

  // decode to execute
  logic      is_load;
  logic      is_store;
  mem_size_t size;
  logic      is_unsigned;
  reg_idx_t  dec_rd;
  xlen_t     imm;
  logic      illegal;

  // execute to memory
  word_idx_t  mem_idx;
  byte_mask_t mem_wmask;
  xlen_t      mem_wdata;
  logic       mem_re;
  xlen_t      mem_rdata;

  // execute to result
  logic      ld_strobe;
  logic      op_strobe;
  byte_off_t ld_off;
  mem_size_t ld_size;
  logic      ld_unsigned;
  reg_idx_t  ld_rd;
  logic      ld_fault;

  lsu_decode u_decode (
    .valid       (valid),
    .instr       (instr),
    .is_load     (is_load),
    .is_store    (is_store),
    .size        (size),
    .is_unsigned (is_unsigned),
    .rd          (dec_rd),
    .imm         (imm),
    .illegal     (illegal)
  );

  lsu_execute u_execute (
    .is_load     (is_load),
    .is_store    (is_store),
    .size        (size),
    .is_unsigned (is_unsigned),
    .rd          (dec_rd),
    .imm         (imm),
    .illegal     (illegal),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .mem_idx     (mem_idx),
    .mem_wmask   (mem_wmask),
    .mem_wdata   (mem_wdata),
    .mem_re      (mem_re),
    .ld_strobe   (ld_strobe),
    .op_strobe   (op_strobe),
    .ld_off      (ld_off),
    .ld_size     (ld_size),
    .ld_unsigned (ld_unsigned),
    .ld_rd       (ld_rd),
    .ld_fault    (ld_fault)
  );

  data_mem u_mem (
    .clk       (clk),
    .mem_idx   (mem_idx),
    .mem_wmask (mem_wmask),
    .mem_wdata (mem_wdata),
    .mem_re    (mem_re),
    .mem_rdata (mem_rdata)
  );

  load_result u_result (
    .clk         (clk),
    .reset       (reset),
    .op_strobe   (op_strobe),
    .ld_strobe   (ld_strobe),
    .ld_off      (ld_off),
    .ld_size     (ld_size),
    .ld_unsigned (ld_unsigned),
    .ld_rd       (ld_rd),
    .ld_fault    (ld_fault),
    .mem_rdata   (mem_rdata),
    .done        (done),
    .rd_we       (rd_we),
    .rd          (rd),
    .rd_data     (rd_data),
    .fault       (fault)
  );

endmodule

`default_nettype wire

// File: source/load_result.sv
`default_nettype none

module load_result
  import rv_isa_pkg::*;
  import mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      op_strobe,
  input  wire logic      ld_strobe,
  input  wire byte_off_t ld_off,
  input  wire mem_size_t ld_size,
  input  wire logic      ld_unsigned,
  input  wire reg_idx_t  ld_rd,
  input  wire logic      ld_fault,
  input  wire xlen_t     mem_rdata,
  output logic           done,
  output logic           rd_we,
  output reg_idx_t       rd,
  output xlen_t          rd_data,
  output logic           fault
);

  logic      done_q;
  logic      load_q;
  logic      fault_q;
  byte_off_t off_q;
  mem_size_t size_q;
  logic      uns_q;
  reg_idx_t  rd_q;
  xlen_t     shifted;
  xlen_t     ext;

  // metadata lines up with the registered read data
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q  <= 1'b0;
      load_q  <= 1'b0;
      fault_q <= 1'b0;
      off_q   <= '0;
      size_q  <= SZ_B;
      uns_q   <= 1'b0;
      rd_q    <= '0;
    end else begin
      done_q  <= op_strobe;
      load_q  <= ld_strobe;
      fault_q <= ld_fault;
      off_q   <= ld_off;
      size_q  <= ld_size;
      uns_q   <= ld_unsigned;
      rd_q    <= ld_rd;
    end
  end

  assign shifted = mem_rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SZ_B:    ext = uns_q ? {56'd0, shifted[7:0]}  : {{56{shifted[7]}}, shifted[7:0]};
      SZ_H:    ext = uns_q ? {48'd0, shifted[15:0]} : {{48{shifted[15]}}, shifted[15:0]};
      SZ_W:    ext = uns_q ? {32'd0, shifted[31:0]} : {{32{shifted[31]}}, shifted[31:0]};
      default: ext = shifted;
    endcase
  end

  // x0 is never written
  assign rd_we   = load_q && !fault_q && (rd_q != '0);
  assign rd_data = rd_we ? ext : '0;
  assign rd      = rd_q;
  assign done    = done_q;
  assign fault   = fault_q;

endmodule

`default_nettype wire

// File: source/data_mem.sv
`default_nettype none

module data_mem
  import rv_isa_pkg::*;
  import mem_pkg::*;
(
  input  wire logic       clk,
  input  wire word_idx_t  mem_idx,
  input  wire byte_mask_t mem_wmask,
  input  wire xlen_t      mem_wdata,
  input  wire logic       mem_re,
  output xlen_t           mem_rdata
);

  // storage, contents are undefined after power-up
  xlen_t mem [MEM_WORDS];

  // byte-lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (mem_wmask[i]) begin
        mem[mem_idx][i*8 +: 8] <= mem_wdata[i*8 +: 8];
      end
    end
  end

  // registered read, holds when idle
  always_ff @(posedge clk) begin
    if (mem_re) begin
      mem_rdata <= mem[mem_idx];
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_execute.sv
`default_nettype none

module lsu_execute
  import rv_isa_pkg::*;
  import mem_pkg::*;
(
  input  wire logic      is_load,
  input  wire logic      is_store,
  input  wire mem_size_t size,
  input  wire logic      is_unsigned,
  input  wire reg_idx_t  rd,
  input  wire xlen_t     imm,
  input  wire logic      illegal,
  input  wire xlen_t     rs1_val,
  input  wire xlen_t     rs2_val,
  output word_idx_t      mem_idx,
  output byte_mask_t     mem_wmask,
  output xlen_t          mem_wdata,
  output logic           mem_re,
  output logic           ld_strobe,
  output logic           op_strobe,
  output byte_off_t      ld_off,
  output mem_size_t      ld_size,
  output logic           ld_unsigned,
  output reg_idx_t       ld_rd,
  output logic           ld_fault
);

  xlen_t      addr;
  byte_off_t  off;
  logic       off_bad;
  logic       misaligned;
  byte_mask_t size_mask;
  byte_mask_t lane_mask;
  xlen_t      data_mask;

  // effective address, upper bits beyond the memory just wrap
  assign addr    = rs1_val + imm;
  assign off     = addr[IDX_LSB-1:0];
  assign mem_idx = addr[IDX_MSB:IDX_LSB];

  always_comb begin
    case (size)
      SZ_B: begin
        off_bad   = 1'b0;
        size_mask = 8'h01;
      end
      SZ_H: begin
        off_bad   = off[0];
        size_mask = 8'h03;
      end
      SZ_W: begin
        off_bad   = |off[1:0];
        size_mask = 8'h0f;
      end
      default: begin
        off_bad   = |off;
        size_mask = 8'hff;
      end
    endcase
  end

  // only meaningful for a decoded access
  assign misaligned = (is_load || is_store) && off_bad;

  assign lane_mask = size_mask << off;

  // expand the size mask to bit granularity for the store data
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      data_mask[i*8 +: 8] = {8{size_mask[i]}};
    end
  end

  assign mem_wdata = (rs2_val & data_mask) << {off, 3'b000};
  assign mem_wmask = (is_store && !misaligned) ? lane_mask : '0;
  assign mem_re    = is_load && !misaligned;

  // metadata handed to the result stage
  assign op_strobe   = is_load || is_store || illegal;
  assign ld_strobe   = is_load;
  assign ld_off      = off;
  assign ld_size     = size;
  assign ld_unsigned = is_unsigned;
  assign ld_rd       = rd;
  assign ld_fault    = illegal || misaligned;

endmodule

`default_nettype wire

// File: source/lsu_decode.sv
`default_nettype none

module lsu_decode
  import rv_isa_pkg::*;
  import mem_pkg::*;
(
  input  wire logic valid,
  input  wire instr_t instr,
  output logic      is_load,
  output logic      is_store,
  output mem_size_t size,
  output logic      is_unsigned,
  output reg_idx_t  rd,
  output xlen_t     imm,
  output logic      illegal
);

  opcode_t opcode;
  funct3_t funct3;
  logic    opc_load;
  logic    opc_store;
  xlen_t   imm_i;
  xlen_t   imm_s;

  assign opcode = instr[OPC_LSB +: 7];
  assign funct3 = instr[F3_LSB +: 3];

  assign opc_load  = (opcode == OPC_LOAD);
  assign opc_store = (opcode == OPC_STORE);

  // I-type for loads, S-type for stores
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};

  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    if (valid && opc_load) begin
      // funct3 7 has no load form
      is_load = (funct3 != 3'd7);
    end
    if (valid && opc_store) begin
      // only sb, sh, sw, sd exist
      is_store = (funct3 <= F3_D);
    end
  end

  // anything valid that did not decode
  assign illegal = valid && !is_load && !is_store;

  // low two bits give the size, bit 2 marks the unsigned forms
  assign size        = funct3[1:0];
  assign is_unsigned = (funct3 == F3_BU) || (funct3 == F3_HU) || (funct3 == F3_WU);

  assign rd  = instr[RD_LSB +: 5];
  assign imm = opc_store ? imm_s : imm_i;

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // 256 doublewords, 2 KiB total
  localparam int MEM_WORDS = 256;

  // word index comes from address bits 10..3
  localparam int IDX_LSB = 3;
  localparam int IDX_MSB = 10;

  typedef logic [IDX_MSB-IDX_LSB:0] word_idx_t;
  typedef logic [7:0]               byte_mask_t;
  typedef logic [IDX_LSB-1:0]       byte_off_t;
  typedef logic [1:0]               mem_size_t;

  // access sizes
  localparam mem_size_t SZ_B = 2'd0;
  localparam mem_size_t SZ_H = 2'd1;
  localparam mem_size_t SZ_W = 2'd2;
  localparam mem_size_t SZ_D = 2'd3;

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // instruction word and register-sized values
  typedef logic [31:0] instr_t;
  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  opcode_t;

  // major opcodes handled by the lsu
  localparam opcode_t OPC_LOAD  = 7'b0000011;
  localparam opcode_t OPC_STORE = 7'b0100011;

  // funct3 encodings, signed or store forms
  localparam funct3_t F3_B  = 3'd0;
  localparam funct3_t F3_H  = 3'd1;
  localparam funct3_t F3_W  = 3'd2;
  localparam funct3_t F3_D  = 3'd3;

  // unsigned load forms
  localparam funct3_t F3_BU = 3'd4;
  localparam funct3_t F3_HU = 3'd5;
  localparam funct3_t F3_WU = 3'd6;

  // field positions inside the instruction word
  localparam int OPC_LSB = 0;
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;

endpackage

`default_nettype wire
